//--- verilog/mem_pkg.sv
// memory-access opcode enum and CPU-side width parameters
`default_nettype none

package mem_pkg;

    // CPU data width
    parameter int XLEN = 64;

    // byte address width
    parameter int ADDR_W = 32;

    // bytes per CPU word
    parameter int STRB_W = XLEN / 8;

    // width and sign of a load or store
    // low two bits give the size, bit 2 marks a zero-extended load
    typedef enum logic [2:0] {
        OP_WORD   = 3'b000,
        OP_BYTE   = 3'b001,
        OP_HALF   = 3'b010,
        OP_DOUBLE = 3'b011,
        OP_WORD_U = 3'b100,
        OP_BYTE_U = 3'b101,
        OP_HALF_U = 3'b110
    } mem_op_e;

endpackage

`default_nettype wire

//--- verilog/cache_pkg.sv
// data cache geometry constants and controller state enum
`default_nettype none

package cache_pkg;

    // memory port beat width
    parameter int BEAT_W = 128;

    // beats per refill
    parameter int BEATS_PER_LINE = 2;

    parameter int LINE_W = BEAT_W * BEATS_PER_LINE;

    // byte offset bits within a line
    parameter int OFFSET_W = $clog2(LINE_W / 8);

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        WRITE_THRU,
        DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- verilog/store_align.sv
// store data lane placement and byte mask generation
`timescale 1ns/1ps
`default_nettype none

module store_align import mem_pkg::*; (
    input  mem_op_e           memop_i,
    input  logic [2:0]        addr_lo_i,
    input  logic [XLEN-1:0]   wdata_i,
    output logic [XLEN-1:0]   data_o,
    output logic [STRB_W-1:0] mask_o
);

    logic [XLEN-1:0]   low_data;
    logic [STRB_W-1:0] low_mask;

    // keep only the bytes of the access size, still in lane 0
    always_comb begin
        case (memop_i)
            OP_BYTE, OP_BYTE_U: begin
                low_data = {{(XLEN-8){1'b0}}, wdata_i[7:0]};
                low_mask = STRB_W'(8'h01);
            end
            OP_HALF, OP_HALF_U: begin
                low_data = {{(XLEN-16){1'b0}}, wdata_i[15:0]};
                low_mask = STRB_W'(8'h03);
            end
            OP_WORD, OP_WORD_U: begin
                low_data = {{(XLEN-32){1'b0}}, wdata_i[31:0]};
                low_mask = STRB_W'(8'h0f);
            end
            OP_DOUBLE: begin
                low_data = wdata_i;
                low_mask = '1;
            end
            default: begin
                low_data = '0;
                low_mask = '0;
            end
        endcase
    end

    // move to the addressed lane
    assign data_o = low_data << {addr_lo_i, 3'b000};
    assign mask_o = low_mask << addr_lo_i;

endmodule

`default_nettype wire

//--- verilog/load_extend.sv
// load byte selection with sign or zero extension
`timescale 1ns/1ps
`default_nettype none

module load_extend import mem_pkg::*; (
    input  mem_op_e         memop_i,
    input  logic [2:0]      addr_lo_i,
    input  logic [XLEN-1:0] word_i,
    output logic [XLEN-1:0] rdata_o
);

    logic [XLEN-1:0] shifted;

    // addressed byte down to lane 0
    assign shifted = word_i >> {addr_lo_i, 3'b000};

    always_comb begin
        case (memop_i)
            OP_WORD:   rdata_o = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
            OP_BYTE:   rdata_o = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            OP_HALF:   rdata_o = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            OP_DOUBLE: rdata_o = word_i;
            OP_WORD_U: rdata_o = {{(XLEN-32){1'b0}}, shifted[31:0]};
            OP_BYTE_U: rdata_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
            OP_HALF_U: rdata_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
            // unused encoding
            default:   rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/beat_counter.sv
// refill beat index counter with last-beat flag
`timescale 1ns/1ps
`default_nettype none

module beat_counter import cache_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic clear_i,
    input  logic step_i,
    output logic beat_o,
    output logic last_o
);

    logic beat_q;

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            beat_q <= 1'b0;
        end else if (step_i) begin
            // wrap after the final beat of a line
            beat_q <= last_o ? 1'b0 : beat_q + 1'b1;
        end
    end

    assign beat_o = beat_q;
    assign last_o = (beat_q == 1'(BEATS_PER_LINE - 1));

endmodule

`default_nettype wire

//--- verilog/dcache_array.sv
// direct-mapped cache storage with hit lookup, beat fill, masked write and flush
`timescale 1ns/1ps
`default_nettype none

module dcache_array import mem_pkg::*; import cache_pkg::*; #(
    parameter int LINE_COUNT = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic              fill_i,
    input  logic              beat_i,
    input  logic [BEAT_W-1:0] fill_data_i,
    input  logic              wr_i,
    input  logic [XLEN-1:0]   wr_data_i,
    input  logic [STRB_W-1:0] wr_mask_i,
    input  logic              flush_i,
    output logic              hit_o,
    output logic [XLEN-1:0]   word_o
);

    localparam int IDX_W  = $clog2(LINE_COUNT);
    localparam int TAG_W  = ADDR_W - OFFSET_W - IDX_W;
    localparam int WSEL_W = $clog2(LINE_W / XLEN);

    logic [LINE_COUNT-1:0] valid_q;
    logic [TAG_W-1:0]      tag_q  [LINE_COUNT];
    logic [LINE_W-1:0]     line_q [LINE_COUNT];

    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic [WSEL_W-1:0] wsel;
    logic              fill_last;

    // address split
    assign idx  = addr_i[OFFSET_W +: IDX_W];
    assign tag  = addr_i[ADDR_W-1 -: TAG_W];
    assign wsel = addr_i[OFFSET_W-1 -: WSEL_W];

    assign fill_last = (beat_i == 1'(BEATS_PER_LINE - 1));

    assign hit_o  = valid_q[idx] && (tag_q[idx] == tag);
    assign word_o = line_q[idx][wsel*XLEN +: XLEN];

    // line stays invalid until its last beat lands
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[idx] <= fill_last;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            line_q[idx][beat_i*BEAT_W +: BEAT_W] <= fill_data_i;
            tag_q[idx] <= tag;
        end else if (wr_i) begin
            // byte merge on a write hit
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_mask_i[b]) begin
                    line_q[idx][wsel*XLEN + b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
// data cache controller FSM for lookup, refill, write-through and completion
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import cache_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic req_valid_i,
    input  logic req_we_i,
    input  logic hit_i,
    input  logic last_beat_i,
    input  logic mem_ready_i,
    input  logic flush_i,
    output logic fill_o,
    output logic wr_o,
    output logic clear_valid_o,
    output logic beat_clear_o,
    output logic beat_step_o,
    output logic mem_req_o,
    output logic mem_we_o,
    output logic busy_o,
    output logic done_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                // stores always go to memory, hit or miss
                if (req_we_i) begin
                    state_d = WRITE_THRU;
                end else if (hit_i) begin
                    state_d = DONE;
                end else begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ready_i && last_beat_i) begin
                    state_d = DONE;
                end
            end
            WRITE_THRU: begin
                if (mem_ready_i) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // flush only taken while idle
    assign clear_valid_o = (state_q == IDLE) && flush_i;

    // write hit updates the line during lookup
    assign wr_o = (state_q == LOOKUP) && req_we_i && hit_i;

    assign beat_clear_o = (state_q == LOOKUP);

    // one beat accepted per ready pulse
    assign fill_o      = (state_q == REFILL) && mem_ready_i;
    assign beat_step_o = fill_o;

    assign mem_req_o = (state_q == REFILL) || (state_q == WRITE_THRU);
    assign mem_we_o  = (state_q == WRITE_THRU);

    assign busy_o = ((state_q == IDLE) && req_valid_i) || (state_q == LOOKUP) ||
                    mem_req_o;
    assign done_o = (state_q == DONE);

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
// memory-access stage top with store/load aligners, data cache array, controller and beat counter
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mem_pkg::*; import cache_pkg::*; #(
    parameter int LINE_COUNT = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid_i,
    input  logic                req_we_i,
    input  mem_op_e             memop_i,
    input  logic [ADDR_W-1:0]   addr_i,
    input  logic [XLEN-1:0]     wdata_i,
    input  logic                flush_i,
    output logic [XLEN-1:0]     rdata_o,
    output logic                busy_o,
    output logic                done_o,
    output logic                mem_req_o,
    output logic                mem_we_o,
    output logic [ADDR_W-1:0]   mem_addr_o,
    output logic [BEAT_W-1:0]   mem_wdata_o,
    output logic [BEAT_W/8-1:0] mem_wstrb_o,
    input  logic [BEAT_W-1:0]   mem_rdata_i,
    input  logic                mem_ready_i
);

    localparam int BEAT_OFF_W = $clog2(BEAT_W / 8);

    logic [XLEN-1:0]   st_data;
    logic [STRB_W-1:0] st_mask;
    logic [XLEN-1:0]   cache_word;
    logic              hit;
    logic              fill;
    logic              wr;
    logic              clear_valid;
    logic              beat_clear;
    logic              beat_step;
    logic              beat;
    logic              last_beat;
    logic [ADDR_W-1:0] refill_addr;
    logic [ADDR_W-1:0] thru_addr;

    store_align store_align_i (
        .memop_i   (memop_i),
        .addr_lo_i (addr_i[2:0]),
        .wdata_i   (wdata_i),
        .data_o    (st_data),
        .mask_o    (st_mask)
    );

    load_extend load_extend_i (
        .memop_i   (memop_i),
        .addr_lo_i (addr_i[2:0]),
        .word_i    (cache_word),
        .rdata_o   (rdata_o)
    );

    beat_counter beat_counter_i (
        .clk     (clk),
        .rst     (rst),
        .clear_i (beat_clear),
        .step_i  (beat_step),
        .beat_o  (beat),
        .last_o  (last_beat)
    );

    dcache_array #(
        .LINE_COUNT (LINE_COUNT)
    ) dcache_array_i (
        .clk         (clk),
        .rst         (rst),
        .addr_i      (addr_i),
        .fill_i      (fill),
        .beat_i      (beat),
        .fill_data_i (mem_rdata_i),
        .wr_i        (wr),
        .wr_data_i   (st_data),
        .wr_mask_i   (st_mask),
        .flush_i     (clear_valid),
        .hit_o       (hit),
        .word_o      (cache_word)
    );

    dcache_ctrl dcache_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid_i   (req_valid_i),
        .req_we_i      (req_we_i),
        .hit_i         (hit),
        .last_beat_i   (last_beat),
        .mem_ready_i   (mem_ready_i),
        .flush_i       (flush_i),
        .fill_o        (fill),
        .wr_o          (wr),
        .clear_valid_o (clear_valid),
        .beat_clear_o  (beat_clear),
        .beat_step_o   (beat_step),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    // line base plus beat index
    assign refill_addr = {addr_i[ADDR_W-1:OFFSET_W], beat, {BEAT_OFF_W{1'b0}}};
    assign thru_addr   = {addr_i[ADDR_W-1:BEAT_OFF_W], {BEAT_OFF_W{1'b0}}};

    assign mem_addr_o = mem_we_o ? thru_addr : refill_addr;

    // same doubleword on both halves, strobe picks the addressed one
    assign mem_wdata_o = {(BEAT_W / XLEN){st_data}};
    assign mem_wstrb_o = {{(BEAT_W/8 - STRB_W){1'b0}}, st_mask} <<
                         {addr_i[BEAT_OFF_W-1:3], 3'b000};

endmodule

`default_nettype wire

//--- tests/tb_mem_model.svh
// model memory, LFSR, value check task and reference load/store functions
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH
`default_nettype none

localparam logic [31:0] WIN_BASE  = 32'h0000_1000;
localparam int          WIN_BYTES = 512;

logic [7:0]  model_mem [WIN_BYTES];
logic [31:0] lfsr_q = 32'h79f;

task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
endtask

task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
        $display("MISMATCH %s got %0h expected %0h", name, got, exp);
        $display("TB FAILED");
        $fatal(1);
    end
endtask

// initial memory contents, every address bit matters
function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return 8'(a * 37) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
endfunction

// fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        r = {r[30:0], fb};
    end
    return r;
endfunction

function automatic int op_bytes(input mem_op_e op);
    case (op)
        OP_BYTE, OP_BYTE_U: return 1;
        OP_HALF, OP_HALF_U: return 2;
        OP_DOUBLE:          return 8;
        default:            return 4;
    endcase
endfunction

// little-endian gather, signed ops extend the top bit
function automatic logic [63:0] load_ref(input mem_op_e op, input logic [31:0] a);
    logic [63:0] v;
    int          n;
    n = op_bytes(op);
    v = '0;
    for (int i = 0; i < n; i++) begin
        v[i*8 +: 8] = model_mem[a - WIN_BASE + i];
    end
    if (op == OP_BYTE || op == OP_HALF || op == OP_WORD) begin
        for (int i = n * 8; i < 64; i++) begin
            v[i] = v[n*8-1];
        end
    end
    return v;
endfunction

function automatic logic [15:0] store_strobe(input mem_op_e op, input logic [31:0] a);
    return 16'(((1 << op_bytes(op)) - 1) << a[3:0]);
endfunction

// expected store byte on one lane of the 16-byte beat
function automatic logic [7:0] store_lane(input logic [63:0] wd, input logic [31:0] a,
                                          input int lane);
    int off;
    off = a[3:0];
    return wd[(lane - off) * 8 +: 8];
endfunction

`default_nettype wire
`endif

//--- tests/tb_mem_stage.sv
// testbench for the memory-access stage with random requests, memory responder and scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage import mem_pkg::*; ();

    localparam int LINE_COUNT   = 8;
    localparam int LINE_BYTES   = 32;
    localparam int N_REQ        = 400;
    localparam int REQ_CYCLES   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + N_REQ * REQ_CYCLES + 10) * 20;

    logic          clk;
    logic          rst;
    logic          req_valid;
    logic          req_we;
    mem_op_e       memop;
    logic [31:0]   addr;
    logic [63:0]   wdata;
    logic          flush;
    logic [63:0]   rdata;
    logic          busy;
    logic          done;
    logic          mem_req;
    logic          mem_we;
    logic [31:0]   mem_addr;
    logic [127:0]  mem_wdata;
    logic [15:0]   mem_wstrb;
    logic [127:0]  mem_rdata;
    logic          mem_ready;

    // which lines the testbench expects to be cached
    logic          tag_valid [LINE_COUNT];
    logic [31:0]   tag_line  [LINE_COUNT];

`include "tb_mem_model.svh"

    mem_stage #(
        .LINE_COUNT (LINE_COUNT)
    ) mem_stage_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid),
        .req_we_i    (req_we),
        .memop_i     (memop),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .flush_i     (flush),
        .rdata_o     (rdata),
        .busy_o      (busy),
        .done_o      (done),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_wstrb_o (mem_wstrb),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before all requests completed");
    end

    // one request, serving the memory port until done
    task automatic run_access(input logic we, input mem_op_e op, input logic [31:0] a,
                              input logic [63:0] wd);
        int           idx;
        int           cycles;
        int           reads;
        int           writes;
        int           wait_left;
        logic         pending;
        logic         finished;
        logic         exp_hit;
        logic [63:0]  exp_load;
        logic [15:0]  exp_strb;
        logic [31:0]  snap_addr;
        logic [127:0] snap_wdata;
        logic [15:0]  snap_strb;
        logic         snap_we;
        idx = (a / LINE_BYTES) % LINE_COUNT;
        exp_hit = !we && tag_valid[idx] && (tag_line[idx] == a / LINE_BYTES);
        exp_load = load_ref(op, a);
        exp_strb = store_strobe(op, a);
        cycles = 0;
        reads = 0;
        writes = 0;
        wait_left = 0;
        pending = 1'b0;
        finished = 1'b0;
        req_valid = 1'b1;
        req_we = we;
        memop = op;
        addr = a;
        wdata = wd;
        flush = 1'b0;
        // busy already in the first request cycle
        #1;
        check_val("busy_o", busy, 1'b1);
        while (!finished) begin
            @(posedge clk);
            #1;
            cycles++;
            if (done) begin
                finished = 1'b1;
                check_val("busy_o", busy, 1'b0);
                if (pending) begin
                    abort_run("done_o rose while a memory transfer was still waiting");
                end
                if (!we) begin
                    check_val("rdata_o", rdata, exp_load);
                end
            end else begin
                check_val("busy_o", busy, 1'b1);
                if (mem_req && !pending) begin
                    pending = 1'b1;
                    wait_left = rand_bits(2);
                    snap_addr = mem_addr;
                    snap_wdata = mem_wdata;
                    snap_strb = mem_wstrb;
                    snap_we = mem_we;
                    check_val("mem_we_o", mem_we, we);
                    if (we) begin
                        writes++;
                        check_val("mem_addr_o", mem_addr, a & ~32'hf);
                        check_val("mem_wstrb_o", mem_wstrb, exp_strb);
                        for (int b = 0; b < 16; b++) begin
                            if (exp_strb[b]) begin
                                check_val("mem_wdata_o", mem_wdata[b*8 +: 8],
                                          store_lane(wd, a, b));
                            end
                        end
                    end else begin
                        check_val("mem_addr_o", mem_addr, (a & ~32'h1f) + 32'(reads * 16));
                        reads++;
                    end
                end else if (pending) begin
                    // outputs frozen while ready is withheld
                    check_val("mem_req_o", mem_req, 1'b1);
                    check_val("mem_we_o", mem_we, snap_we);
                    check_val("mem_addr_o", mem_addr, snap_addr);
                    check_val("mem_wdata_o", mem_wdata, snap_wdata);
                    check_val("mem_wstrb_o", mem_wstrb, snap_strb);
                end
            end
            #1;
            mem_ready = 1'b0;
            if (!finished) begin
                // flush while busy must be ignored
                flush = (rand_bits(3) == 0);
                if (pending && wait_left == 0) begin
                    mem_ready = 1'b1;
                    pending = 1'b0;
                    for (int b = 0; b < 16; b++) begin
                        if (snap_we && snap_strb[b]) begin
                            model_mem[snap_addr - WIN_BASE + b] = snap_wdata[b*8 +: 8];
                        end
                        mem_rdata[b*8 +: 8] = model_mem[snap_addr - WIN_BASE + b];
                    end
                end else if (pending) begin
                    wait_left--;
                end
            end
        end
        req_valid = 1'b0;
        flush = 1'b0;
        check_val("write beats", writes, we ? 1 : 0);
        if (!we && exp_hit) begin
            check_val("read beats", reads, 0);
            check_val("done latency", cycles, 2);
        end else if (!we) begin
            check_val("read beats", reads, 2);
            tag_valid[idx] = 1'b1;
            tag_line[idx] = a / LINE_BYTES;
        end else begin
            check_val("read beats", reads, 0);
        end
    endtask

    task automatic run_flush();
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        for (int i = 0; i < LINE_COUNT; i++) begin
            tag_valid[i] = 1'b0;
        end
    endtask

    initial begin
        logic [2:0]  kind;
        logic [2:0]  code;
        mem_op_e     op;
        logic [31:0] a;
        logic [63:0] wd;
        rst = 1'b1;
        req_valid = 1'b0;
        req_we = 1'b0;
        memop = OP_WORD;
        addr = '0;
        wdata = '0;
        flush = 1'b0;
        mem_rdata = '0;
        mem_ready = 1'b0;
        for (int i = 0; i < WIN_BYTES; i++) begin
            model_mem[i] = fill_byte(WIN_BASE + i);
        end
        for (int i = 0; i < LINE_COUNT; i++) begin
            tag_valid[i] = 1'b0;
            tag_line[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        #1;
        check_val("busy_o", busy, 1'b0);
        check_val("done_o", done, 1'b0);
        check_val("mem_req_o", mem_req, 1'b0);
        for (int n = 0; n < N_REQ; n++) begin
            @(posedge clk);
            #2;
            kind = rand_bits(3);
            code = rand_bits(3);
            // 3'b111 is unused, fold it onto double
            op = (code == 3'b111) ? OP_DOUBLE : mem_op_e'(code);
            a = WIN_BASE + (rand_bits(9) & ~32'(op_bytes(op) - 1));
            wd = {rand_bits(32), rand_bits(32)};
            if (kind == 0) begin
                run_flush();
            end else begin
                run_access(kind < 4, op, a, wd);
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_stage.f
+incdir+tests
verilog/mem_pkg.sv
verilog/cache_pkg.sv
verilog/store_align.sv
verilog/load_extend.sv
verilog/beat_counter.sv
verilog/dcache_array.sv
verilog/dcache_ctrl.sv
verilog/mem_stage.sv
tests/tb_mem_stage.sv
